//--- logic/tpu_pkg.sv
package tpu_pkg;

    // Array geometry
    localparam int unsigned ARRAY_DIM   = 5;
    localparam int unsigned LANE_W      = 8;
    localparam int unsigned WORD_W      = ARRAY_DIM * LANE_W;
    localparam int unsigned ROW_IDX_W   = $clog2(ARRAY_DIM);

    localparam int unsigned INDEX_W     = 9;
    localparam int unsigned DIM_W       = 4;
    localparam int unsigned CREDIT_W    = 2;

    // Phase lengths per chunk
    localparam int unsigned LOAD_CYCLES = ARRAY_DIM + 1;
    localparam int unsigned EXE_CYCLES  = 14;

    localparam int unsigned CREDIT_INIT = 2;
    localparam int unsigned MAX_K       = 15;

    // Feeder window and de-skew depth
    localparam int unsigned FEED_LEN    = 2 * ARRAY_DIM;
    localparam int unsigned DESKEW_LEN  = 2 * ARRAY_DIM - 1;

    typedef logic [LANE_W-1:0]    lane_t;
    // Byte 4 is lane 0
    typedef logic [WORD_W-1:0]    row_word_t;
    typedef logic [INDEX_W-1:0]   index_t;
    typedef logic [DIM_W-1:0]     dim_t;
    typedef logic [CREDIT_W-1:0]  credit_t;
    typedef logic [ARRAY_DIM-1:0] row_mask_t;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        EXE,
        STORE,
        OUTPUT,
        DONE
    } tpu_state_t;

endpackage

//--- logic/tile_ctrl_if.sv
`timescale 1ns/10ps

interface tile_ctrl_if import tpu_pkg::*; ();

    row_mask_t load_row;
    logic      load_valid;
    logic      row_zero;
    logic      shift;
    logic      acc_add;
    logic      acc_clr;
    dim_t      rd_row;

    modport ctrl (
        output load_row, load_valid, row_zero, shift, acc_add, acc_clr, rd_row
    );

    modport feeder (input load_row, load_valid, row_zero, shift);

    modport array (input load_row, load_valid, row_zero, shift);

    modport accum (input shift, acc_add, acc_clr, rd_row);

endinterface

//--- logic/pe.sv
`timescale 1ns/10ps

module pe import tpu_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  lane_t left_i,
    input  lane_t up_i,
    input  lane_t weight_i,
    input  logic  weight_en_i,
    input  logic  shift_i,
    output lane_t right_o,
    output lane_t down_o
);

    lane_t weight_q;
    lane_t mac;

    // Wraps modulo 256
    assign mac = up_i + left_i * weight_q;

    always_ff @(posedge clk) begin
        if (weight_en_i) begin
            weight_q <= weight_i;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            right_o <= '0;
            down_o  <= '0;
        end else if (shift_i) begin
            right_o <= left_i;
            down_o  <= mac;
        end
    end

endmodule

//--- logic/pe_array.sv
`timescale 1ns/10ps

module pe_array import tpu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  lane_t [ARRAY_DIM-1:0] left_i,
    input  row_word_t             weight_i,
    tile_ctrl_if.array            ctl,
    output lane_t [ARRAY_DIM-1:0] bottom_o
);

    lane_t     east [ARRAY_DIM][ARRAY_DIM];
    lane_t     south [ARRAY_DIM][ARRAY_DIM];
    lane_t     w_lane [ARRAY_DIM];
    row_mask_t row_en;

    assign row_en = ctl.load_valid ? ctl.load_row : '0;

    for (genvar c = 0; c < ARRAY_DIM; c++) begin : g_wt
        // Rows past k hold zero weights
        assign w_lane[c] = ctl.row_zero ? '0 : weight_i[WORD_W-1-LANE_W*c -: LANE_W];
        assign bottom_o[c] = south[ARRAY_DIM-1][c];
    end

    for (genvar r = 0; r < ARRAY_DIM; r++) begin : g_row
        for (genvar c = 0; c < ARRAY_DIM; c++) begin : g_col
            lane_t act_in;
            lane_t psum_in;

            if (c == 0) begin : g_west_edge
                assign act_in = left_i[r];
            end else begin : g_west_inner
                assign act_in = east[r][c-1];
            end

            if (r == 0) begin : g_top_edge
                assign psum_in = '0;
            end else begin : g_top_inner
                assign psum_in = south[r-1][c];
            end

            pe u_pe (
                .clk         (clk),
                .rst         (rst),
                .left_i      (act_in),
                .up_i        (psum_in),
                .weight_i    (w_lane[c]),
                .weight_en_i (row_en[r]),
                .shift_i     (ctl.shift),
                .right_o     (east[r][c]),
                .down_o      (south[r][c])
            );
        end
    end

endmodule

//--- logic/skew_feeder.sv
`timescale 1ns/10ps

module skew_feeder import tpu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  row_word_t             data_a_i,
    tile_ctrl_if.feeder           ctl,
    output lane_t [ARRAY_DIM-1:0] left_o
);

    typedef logic [FEED_LEN*LANE_W-1:0] feed_word_t;

    row_word_t col_word;

    assign col_word = ctl.row_zero ? '0 : data_a_i;

    for (genvar r = 0; r < ARRAY_DIM; r++) begin : g_row
        lane_t      buf_q [FEED_LEN];
        feed_word_t staged;

        // Column sits r lanes back so row r starts r cycles late
        assign staged = {col_word, {WORD_W{1'b0}}} >> (LANE_W * r);

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                for (int p = 0; p < FEED_LEN; p++) begin
                    buf_q[p] <= '0;
                end
            end else if (ctl.load_valid && ctl.load_row[r]) begin
                for (int p = 0; p < FEED_LEN; p++) begin
                    buf_q[p] <= staged[FEED_LEN*LANE_W-1-LANE_W*p -: LANE_W];
                end
            end else if (ctl.shift) begin
                for (int p = 0; p < FEED_LEN - 1; p++) begin
                    buf_q[p] <= buf_q[p+1];
                end
                buf_q[FEED_LEN-1] <= '0;
            end
        end

        assign left_o[r] = buf_q[0];
    end

endmodule

//--- logic/result_accum.sv
`timescale 1ns/10ps

module result_accum import tpu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  lane_t [ARRAY_DIM-1:0] bottom_i,
    tile_ctrl_if.accum            ctl,
    output row_word_t             rd_data_o
);

    lane_t     dly_q [ARRAY_DIM][DESKEW_LEN];
    row_word_t acc_q [ARRAY_DIM];
    row_word_t sum_d [ARRAY_DIM];

    // One delay line per column, tap 0 is the newest sample
    always_ff @(posedge clk) begin
        if (ctl.shift) begin
            for (int c = 0; c < ARRAY_DIM; c++) begin
                dly_q[c][0] <= bottom_i[c];
                for (int j = 1; j < DESKEW_LEN; j++) begin
                    dly_q[c][j] <= dly_q[c][j-1];
                end
            end
        end
    end

    // Row i of column c left the array 8-i-c shifts before the end
    always_comb begin
        for (int i = 0; i < ARRAY_DIM; i++) begin
            for (int c = 0; c < ARRAY_DIM; c++) begin
                sum_d[i][WORD_W-1-LANE_W*c -: LANE_W] =
                    acc_q[i][WORD_W-1-LANE_W*c -: LANE_W] + dly_q[c][DESKEW_LEN-1-i-c];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < ARRAY_DIM; i++) begin
                acc_q[i] <= '0;
            end
        end else if (ctl.acc_clr) begin
            for (int i = 0; i < ARRAY_DIM; i++) begin
                acc_q[i] <= '0;
            end
        end else if (ctl.acc_add) begin
            for (int i = 0; i < ARRAY_DIM; i++) begin
                acc_q[i] <= sum_d[i];
            end
        end
    end

    assign rd_data_o = acc_q[ctl.rd_row[ROW_IDX_W-1:0]];

    a_add_not_shift: assert property (@(posedge clk) disable iff (rst)
        !(ctl.acc_add && ctl.shift))
        else $error("accumulate during shift");

    // Taps are only aligned right after a shift phase
    a_add_after_shift: assert property (@(posedge clk) disable iff (rst)
        ctl.acc_add |-> $past(ctl.shift))
        else $error("accumulate without preceding shift");

endmodule

//--- logic/tpu_ctrl.sv
`timescale 1ns/10ps

module tpu_ctrl import tpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      start_i,
    input  dim_t      m_i,
    input  dim_t      k_i,
    output index_t    index_a_o,
    output index_t    index_b_o,
    output logic      out_valid_o,
    output dim_t      out_row_o,
    input  logic      credit_return_i,
    output logic      busy_o,
    output logic      done_o,
    tile_ctrl_if.ctrl ctl
);

    tpu_state_t state_q;
    tpu_state_t state_d;
    dim_t       step_q;
    dim_t       m_q;
    dim_t       k_q;
    dim_t       out_row_q;
    index_t     chunk_base_q;
    index_t     cap_idx;
    credit_t    credit_q;
    logic       accept;
    logic       load_valid;
    logic       send;
    logic       last_load;
    logic       last_exe;
    logic       last_chunk;
    logic       last_row;

    assign accept     = start_i && (state_q == IDLE || state_q == DONE);
    assign last_load  = step_q == dim_t'(LOAD_CYCLES - 1);
    assign last_exe   = step_q == dim_t'(EXE_CYCLES - 1);
    assign last_chunk = (chunk_base_q + index_t'(ARRAY_DIM)) >= index_t'(k_q);
    assign last_row   = out_row_q == (m_q - dim_t'(1));
    assign send       = (state_q == OUTPUT) && (credit_q != '0);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE, DONE: begin
                if (start_i) state_d = LOAD;
            end
            LOAD: begin
                if (last_load) state_d = EXE;
            end
            EXE: begin
                if (last_exe) state_d = STORE;
            end
            STORE: begin
                state_d = last_chunk ? OUTPUT : LOAD;
            end
            OUTPUT: begin
                if (send && last_row) state_d = DONE;
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q      <= IDLE;
            step_q       <= '0;
            m_q          <= '0;
            k_q          <= '0;
            out_row_q    <= '0;
            chunk_base_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_d != state_q) begin
                step_q <= '0;
            end else if (state_q == LOAD || state_q == EXE) begin
                step_q <= step_q + dim_t'(1);
            end
            if (accept) begin
                m_q          <= m_i;
                k_q          <= k_i;
                out_row_q    <= '0;
                chunk_base_q <= '0;
            end
            if (state_q == STORE && !last_chunk) begin
                chunk_base_q <= chunk_base_q + index_t'(ARRAY_DIM);
            end
            if (send) begin
                out_row_q <= out_row_q + dim_t'(1);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credit_q <= credit_t'(CREDIT_INIT);
        end else begin
            credit_q <= credit_q - credit_t'(send) + credit_t'(credit_return_i);
        end
    end

    // Same index to both memories, data lands one step later
    assign index_a_o = chunk_base_q + index_t'(step_q);
    assign index_b_o = chunk_base_q + index_t'(step_q);

    assign load_valid = (state_q == LOAD) && (step_q != '0);
    assign cap_idx    = chunk_base_q + index_t'(step_q) - index_t'(1);

    assign ctl.load_valid = load_valid;
    assign ctl.load_row   = load_valid ? (row_mask_t'(1) << (step_q - dim_t'(1))) : '0;
    assign ctl.row_zero   = cap_idx >= index_t'(k_q);
    assign ctl.shift      = state_q == EXE;
    assign ctl.acc_add    = state_q == STORE;
    assign ctl.acc_clr    = accept;
    assign ctl.rd_row     = out_row_q;

    assign out_valid_o = send;
    assign out_row_o   = out_row_q;
    assign busy_o      = state_q inside {LOAD, EXE, STORE, OUTPUT};
    assign done_o      = state_q == DONE;

    a_credit_range: assert property (@(posedge clk) disable iff (rst)
        credit_q <= credit_t'(CREDIT_INIT))
        else $error("credit count out of range");

    a_row_in_range: assert property (@(posedge clk) disable iff (rst)
        out_valid_o |-> out_row_o < m_q)
        else $error("row sent past m");

    a_k_range: assert property (@(posedge clk) disable iff (rst)
        accept |-> (k_i != '0 && k_i <= dim_t'(MAX_K)))
        else $error("k outside supported range");

endmodule

//--- logic/tpu_top.sv
`timescale 1ns/10ps

module tpu_top import tpu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      start_i,
    input  dim_t      m_i,
    input  dim_t      n_i,
    input  dim_t      k_i,
    output index_t    index_a_o,
    output index_t    index_b_o,
    input  row_word_t data_a_i,
    input  row_word_t data_b_i,
    output logic      out_valid_o,
    output dim_t      out_row_o,
    output row_word_t out_data_o,
    input  logic      credit_return_i,
    output logic      busy_o,
    output logic      done_o
);

    lane_t [ARRAY_DIM-1:0] feed_lanes;
    lane_t [ARRAY_DIM-1:0] bottom_lanes;

    tile_ctrl_if ctl_if ();

    // Lanes past n carry don't-care products
    tpu_ctrl u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .start_i         (start_i),
        .m_i             (m_i),
        .k_i             (k_i),
        .index_a_o       (index_a_o),
        .index_b_o       (index_b_o),
        .out_valid_o     (out_valid_o),
        .out_row_o       (out_row_o),
        .credit_return_i (credit_return_i),
        .busy_o          (busy_o),
        .done_o          (done_o),
        .ctl             (ctl_if)
    );

    skew_feeder u_feeder (
        .clk      (clk),
        .rst      (rst),
        .data_a_i (data_a_i),
        .ctl      (ctl_if),
        .left_o   (feed_lanes)
    );

    pe_array u_array (
        .clk      (clk),
        .rst      (rst),
        .left_i   (feed_lanes),
        .weight_i (data_b_i),
        .ctl      (ctl_if),
        .bottom_o (bottom_lanes)
    );

    result_accum u_accum (
        .clk       (clk),
        .rst       (rst),
        .bottom_i  (bottom_lanes),
        .ctl       (ctl_if),
        .rd_data_o (out_data_o)
    );

endmodule

//--- test/tpu_model.svh
`ifndef TPU_MODEL_SVH
`define TPU_MODEL_SVH

// Operand matrices and the expected 8-bit product
lane_t     a_mat [ARRAY_DIM][MAX_K];
lane_t     b_mat [MAX_K][ARRAY_DIM];
lane_t     c_exp [ARRAY_DIM][ARRAY_DIM];
row_word_t mem_a [MEM_DEPTH];
row_word_t mem_b [MEM_DEPTH];

task automatic fill_operands(input int k);
    for (int r = 0; r < ARRAY_DIM; r++) begin
        for (int kk = 0; kk < MAX_K; kk++) begin
            a_mat[r][kk] = lane_t'($random(seed));
            b_mat[kk][r] = lane_t'($random(seed));
        end
    end
    // Word i holds A column i and B row i, words past k are unrelated noise
    for (int i = 0; i < MEM_DEPTH; i++) begin
        mem_a[i] = row_word_t'({$random(seed), $random(seed)});
        mem_b[i] = row_word_t'({$random(seed), $random(seed)});
        if (i < k) begin
            for (int r = 0; r < ARRAY_DIM; r++) begin
                mem_a[i][WORD_W-1-LANE_W*r -: LANE_W] = a_mat[r][i];
                mem_b[i][WORD_W-1-LANE_W*r -: LANE_W] = b_mat[i][r];
            end
        end
    end
endtask

task automatic compute_expected(input int k);
    int sum;
    for (int i = 0; i < ARRAY_DIM; i++) begin
        for (int j = 0; j < ARRAY_DIM; j++) begin
            sum = 0;
            for (int kk = 0; kk < k; kk++) begin
                sum += int'(a_mat[i][kk]) * int'(b_mat[kk][j]);
            end
            c_exp[i][j] = lane_t'(sum % 256);
        end
    end
endtask

function automatic row_word_t expected_row(input int i);
    row_word_t w;
    for (int j = 0; j < ARRAY_DIM; j++) begin
        w[WORD_W-1-LANE_W*j -: LANE_W] = c_exp[i][j];
    end
    return w;
endfunction

`endif

//--- test/tpu_tb.sv
`timescale 1ns/10ps

module tpu_tb import tpu_pkg::*; ();

    localparam int MEM_DEPTH      = 16;
    localparam int TIMEOUT_CYCLES = 1000;

    logic      clk;
    logic      rst;
    logic      start_i;
    dim_t      m_i;
    dim_t      n_i;
    dim_t      k_i;
    index_t    index_a_o;
    index_t    index_b_o;
    row_word_t data_a_i;
    row_word_t data_b_i;
    logic      out_valid_o;
    dim_t      out_row_o;
    row_word_t out_data_o;
    logic      credit_return_i;
    logic      busy_o;
    logic      done_o;

    integer    seed;
    int        errors;
    int        tests_run;
    int        tests_failed;
    int        cycle;
    int        rows_rx;
    int        credits_ret;
    index_t    idx_a_q;
    index_t    idx_b_q;
    dim_t      rx_row_q [$];
    row_word_t rx_data_q [$];
    int        due_q [$];

    `include "tpu_model.svh"

    tpu_top u_tpu_top (.*);

    always #10 clk = ~clk;

    function automatic int pick_range(input int lo, input int hi);
        int r;
        r = $random(seed);
        return lo + ((r & 32'h7fffffff) % (hi - lo + 1));
    endfunction

    function automatic row_word_t lane_mask(input int n);
        row_word_t w;
        w = '0;
        for (int j = 0; j < n; j++) begin
            w[WORD_W-1-LANE_W*j -: LANE_W] = '1;
        end
        return w;
    endfunction

    task automatic check_value(input string name, input row_word_t exp, input row_word_t act);
        assert (exp === act) else begin
            $display("Error %s expected %0h actual %0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic close_test(input string name, input int err_before);
        tests_run++;
        if (errors != err_before) begin
            tests_failed++;
            $display("test %s failed", name);
        end else begin
            $display("test %s ok", name);
        end
    endtask

    // Registered memories, index sampled mid-cycle, data one cycle later
    always @(negedge clk) begin
        idx_a_q = index_a_o;
        idx_b_q = index_b_o;
    end

    always @(posedge clk) begin
        #1;
        data_a_i = int'(idx_a_q) < MEM_DEPTH ? mem_a[idx_a_q] : '0;
        data_b_i = int'(idx_b_q) < MEM_DEPTH ? mem_b[idx_b_q] : '0;
    end

    // One credit pulse per cycle once its due cycle is reached
    always @(posedge clk) begin
        cycle++;
        #1;
        if (due_q.size() > 0 && cycle >= due_q[0]) begin
            credit_return_i = 1'b1;
            void'(due_q.pop_front());
            credits_ret++;
        end else begin
            credit_return_i = 1'b0;
        end
    end

    always @(negedge clk) begin : rx_monitor
        int due;
        if (!rst && out_valid_o) begin
            rx_row_q.push_back(out_row_o);
            rx_data_q.push_back(out_data_o);
            rows_rx++;
            due = cycle + 1 + pick_range(0, 10);
            if (due_q.size() > 0 && due <= due_q[$]) begin
                due = due_q[$] + 1;
            end
            due_q.push_back(due);
            assert (rows_rx - credits_ret <= int'(CREDIT_INIT)) else begin
                $display("more rows outstanding than credits allow: %0d",
                         rows_rx - credits_ret);
                errors++;
            end
        end
    end

    task automatic run_case(input string name, input int m, input int n, input int k,
                            input int idle);
        int        err_before;
        int        rows_before;
        int        got;
        int        cyc;
        dim_t      act_row;
        row_word_t act_word;
        row_word_t mask;
        err_before  = errors;
        rows_before = rows_rx;
        fill_operands(k);
        compute_expected(k);
        mask = lane_mask(n);
        @(posedge clk);
        #1;
        m_i     = dim_t'(m);
        n_i     = dim_t'(n);
        k_i     = dim_t'(k);
        start_i = 1'b1;
        @(posedge clk);
        #1;
        start_i = 1'b0;
        @(negedge clk);
        check_value({name, " busy_o"}, row_word_t'(1), row_word_t'(busy_o));
        check_value({name, " done_o"}, '0, row_word_t'(done_o));
        got = 0;
        cyc = 0;
        while (got < m && cyc < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cyc++;
            while (rx_row_q.size() > 0 && got < m) begin
                act_row  = rx_row_q.pop_front();
                act_word = rx_data_q.pop_front();
                check_value($sformatf("%s row index", name), row_word_t'(got),
                            row_word_t'(act_row));
                check_value($sformatf("%s row %0d", name, got), expected_row(got) & mask,
                            act_word & mask);
                got++;
            end
        end
        if (got < m) begin
            $display("timeout in %s: only %0d of %0d rows arrived", name, got, m);
            errors++;
        end else begin
            @(negedge clk);
            check_value({name, " done_o"}, row_word_t'(1), row_word_t'(done_o));
            check_value({name, " busy_o"}, '0, row_word_t'(busy_o));
            repeat (idle) begin
                @(negedge clk);
                check_value({name, " done_o held"}, row_word_t'(1), row_word_t'(done_o));
                check_value({name, " out_valid_o"}, '0, row_word_t'(out_valid_o));
            end
            check_value({name, " row count"}, row_word_t'(m),
                        row_word_t'(rows_rx - rows_before));
        end
        close_test(name, err_before);
    endtask

    initial begin
        int err_before;
        seed            = 32'ha7a1;
        clk             = 1'b0;
        rst             = 1'b1;
        start_i         = 1'b0;
        m_i             = '0;
        n_i             = '0;
        k_i             = '0;
        data_a_i        = '0;
        data_b_i        = '0;
        credit_return_i = 1'b0;
        idx_a_q         = '0;
        idx_b_q         = '0;
        errors          = 0;
        tests_run       = 0;
        tests_failed    = 0;
        cycle           = 0;
        rows_rx         = 0;
        credits_ret     = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        err_before = errors;
        repeat (3) begin
            @(negedge clk);
            check_value("idle_after_reset out_valid_o", '0, row_word_t'(out_valid_o));
            check_value("idle_after_reset done_o", '0, row_word_t'(done_o));
            check_value("idle_after_reset busy_o", '0, row_word_t'(busy_o));
        end
        close_test("idle_after_reset", err_before);

        run_case("single_chunk", 5, 5, 5, 2);
        for (int k = 1; k <= 4; k++) begin
            run_case($sformatf("short_k_%0d", k), pick_range(1, 5), pick_range(1, 5), k,
                     pick_range(0, 3));
        end
        for (int i = 0; i < 6; i++) begin
            run_case($sformatf("accumulate_%0d", i), pick_range(1, 5), pick_range(1, 5),
                     pick_range(6, 15), pick_range(0, 3));
        end
        for (int i = 0; i < 4; i++) begin
            run_case($sformatf("back_pressure_%0d", i), pick_range(1, 5), pick_range(1, 5),
                     pick_range(1, 15), 0);
        end
        run_case("done_hold", 5, 5, 12, 8);
        run_case("back_to_back", 5, 5, 7, 0);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+test
logic/tpu_pkg.sv
logic/tile_ctrl_if.sv
logic/pe.sv
logic/pe_array.sv
logic/skew_feeder.sv
logic/result_accum.sv
logic/tpu_ctrl.sv
logic/tpu_top.sv
test/tpu_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tpu_tb -o tpu_sim

out=$(./obj_dir/tpu_sim)
echo "$out"

echo "$out" | grep -q '\*\*\* PASSED \*\*\*'
